// File: dv/sram_model.sv
`timescale 1ns/1ns

module sram_model #(
  parameter int   ADDR_BITS   = 6,
  parameter logic STUCK_VALUE = 1'b1
) (
  input  sram_test_pkg::sram_pins_t      pins,
  inout  wire sram_test_pkg::sram_data_t io_data,
  input  logic                           fault_enable,
  input  logic [ADDR_BITS-1:0]           fault_addr,
  input  logic [3:0]                     fault_bit
);
  import sram_test_pkg::*;

  sram_data_t           mem [2**ADDR_BITS];
  logic [ADDR_BITS-1:0] index;
  logic                 read_en;
  sram_data_t           read_word;

  assign index   = pins.addr[ADDR_BITS-1:0];
  assign read_en = !pins.ce_n && !pins.oe_n && pins.we_n;

  // word latched on the rising edge of we_n
  always @(posedge pins.we_n) begin
    if (!pins.ce_n) begin
      mem[index] <= io_data;
    end
  end

  // stuck-at cell shows up on read
  always_comb begin
    read_word = mem[index];
    if (fault_enable && index == fault_addr) begin
      read_word[fault_bit] = STUCK_VALUE;
    end
  end

  assign io_data = read_en ? read_word : 'z;

endmodule

// File: dv/sram_tester_asserts.sv
`timescale 1ns/1ns

module sram_tester_asserts (
  input logic                      clk,
  input logic                      reset,
  input sram_test_pkg::sram_pins_t pins,
  input logic                      test_done,
  input logic                      test_pass
);

  // no bus contention between read and write
  a_oe_we_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(!pins.oe_n && !pins.we_n))
    else $error("oe_n and we_n low together");

  a_we_needs_ce: assert property (@(posedge clk) disable iff (reset)
    !pins.we_n |-> !pins.ce_n)
    else $error("we_n low while ce_n high");

  a_done_single_cycle: assert property (@(posedge clk) disable iff (reset)
    test_done |=> !test_done)
    else $error("test_done high for more than one cycle");

  // sticky fail flag
  a_pass_sticky: assert property (@(posedge clk) disable iff (reset)
    !test_pass |=> !test_pass)
    else $error("test_pass rose again without reset");

endmodule

bind sram_tester sram_tester_asserts u_asserts (
  .clk      (clk),
  .reset    (reset),
  .pins     (pins),
  .test_done(test_done),
  .test_pass(test_pass)
);

// File: dv/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // power-on reset, released on a falling edge
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// File: dv/tb_sram_tester.sv
`timescale 1ns/1ns

module tb_sram_tester;
  import sram_test_pkg::*;

  localparam int addr_bits   = 6;
  localparam int words       = 2**addr_bits;
  localparam int seq_limit   = 4000;
  localparam int halt_window = 1000;

  logic          clk;
  logic          por_reset;
  logic          soft_reset;
  logic          reset;
  sram_pins_t    pins;
  wire sram_data_t io_data;
  logic          test_done;
  logic          test_pass;
  pattern_kind_e pattern_state;
  check_info_t   last_check;

  logic                 fault_enable;
  logic [addr_bits-1:0] fault_addr;
  logic [3:0]           fault_bit;

  int            error_count;
  int            timeout_count;
  int            done_count;
  int            write_count;
  int            order_idx;
  logic          pass_expected;
  logic          reading;
  logic          prev_we_n;
  logic          prev_oe_n;
  logic [words-1:0] written_mask;
  pattern_kind_e prev_kind;
  logic [31:0]   lfsr_state;
  pattern_kind_e kind_order [5] = '{zeros, ones, checker_a, checker_b, addr_echo};

  assign reset = por_reset || soft_reset;

  tb_clock #(.PERIOD_NS(40), .RESET_CYCLES(3)) u_clock (
    .clk  (clk),
    .reset(por_reset)
  );

  sram_tester #(.ADDR_BITS(addr_bits)) DUT (
    .clk          (clk),
    .reset        (reset),
    .pins         (pins),
    .io_data      (io_data),
    .test_done    (test_done),
    .test_pass    (test_pass),
    .pattern_state(pattern_state),
    .last_check   (last_check)
  );

  sram_model #(.ADDR_BITS(addr_bits)) u_sram (
    .pins        (pins),
    .io_data     (io_data),
    .fault_enable(fault_enable),
    .fault_addr  (fault_addr),
    .fault_bit   (fault_bit)
  );

  // word each pattern kind should put at an address
  function automatic sram_data_t expected_word(pattern_kind_e kind, sram_addr_t addr);
    case (kind)
      zeros:     return 16'h0000;
      ones:      return 16'hffff;
      checker_a: return 16'haaaa;
      checker_b: return 16'h5555;
      addr_echo: return addr[15:0];
      default:   return 16'hxxxx;
    endcase
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  task automatic compare_kind(pattern_kind_e got, pattern_kind_e exp, string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
      error_count++;
    end
  endtask

  task automatic compare_data(sram_data_t got, sram_data_t exp, string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_addr(sram_addr_t got, sram_addr_t exp, string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic compare_bit(logic got, logic exp, string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      error_count++;
    end
  endtask

  task automatic wait_reset_release(input int limit);
    int count;
    count = 0;
    while (reset && count < limit) begin
      @(negedge clk);
      count++;
    end
    if (reset) begin
      $display("reset was still high after %0d cycles", limit);
      timeout_count++;
    end
  endtask

  task automatic wait_done(input int limit);
    int count;
    count = 0;
    @(negedge clk);
    while (!test_done && count < limit) begin
      @(negedge clk);
      count++;
    end
    if (!test_done) begin
      $display("test_done did not pulse within %0d cycles", limit);
      timeout_count++;
    end
  endtask

  task automatic wait_pass_low(input int limit);
    int count;
    count = 0;
    while (test_pass && count < limit) begin
      @(negedge clk);
      count++;
    end
    if (test_pass) begin
      $display("test_pass did not fall within %0d cycles of the fault", limit);
      timeout_count++;
    end
  endtask

  // monitor, samples DUT outputs before they update on this edge
  always @(posedge clk) begin
    if (reset) begin
      reading      <= 1'b1;
      prev_we_n    <= 1'b1;
      prev_oe_n    <= 1'b1;
      written_mask <= '0;
      write_count  <= 0;
      order_idx    <= 0;
      prev_kind    <= zeros;
    end else begin
      if (!pins.ce_n && !pins.we_n) begin
        compare_data(io_data, expected_word(pattern_state, pins.addr), "write data");
      end
      if (!pins.we_n && prev_we_n) begin
        if (reading) begin
          written_mask <= '0;
        end
        reading <= 1'b0;
        written_mask[pins.addr[addr_bits-1:0]] <= 1'b1;
        write_count <= write_count + 1;
      end
      // first read of a pass
      if (!pins.oe_n && prev_oe_n && !reading) begin
        reading <= 1'b1;
        if (written_mask != '1) begin
          $display("** Error at %0t: read sweep began before all %0d addresses were written",
                   $time, words);
          error_count++;
        end
      end
      prev_we_n <= pins.we_n;
      prev_oe_n <= pins.oe_n;
      if (pattern_state != prev_kind) begin
        compare_kind(pattern_state, kind_order[(order_idx + 1) % 5], "pattern_state");
        order_idx <= (order_idx + 1) % 5;
        prev_kind <= pattern_state;
      end
      if (test_done) begin
        compare_kind(pattern_state, addr_echo, "pattern_state at test_done");
        if (write_count != 5 * words) begin
          $display("** Error at %0t: %0d writes in the sequence, expected %0d",
                   $time, write_count, 5 * words);
          error_count++;
        end
        write_count <= 0;
        done_count  <= done_count + 1;
      end
      if (pass_expected) begin
        compare_bit(test_pass, 1'b1, "test_pass");
      end
    end
  end

  initial begin
    logic [31:0] bits;
    int          done_before;
    soft_reset    = 1'b0;
    fault_enable  = 1'b0;
    fault_addr    = '0;
    fault_bit     = '0;
    pass_expected = 1'b1;
    error_count   = 0;
    timeout_count = 0;
    done_count    = 0;
    lfsr_state    = 32'h4a8a_dcbb;

    wait_reset_release(20);

    // two clean sequences
    wait_done(seq_limit);
    wait_done(seq_limit);
    compare_bit(test_pass, 1'b1, "test_pass after two sequences");

    // stuck-at cell at a random address and bit
    take_bits(addr_bits, bits);
    fault_addr = bits[addr_bits-1:0];
    take_bits(4, bits);
    fault_bit     = bits[3:0];
    fault_enable  = 1'b1;
    pass_expected = 1'b0;
    wait_pass_low(seq_limit);
    done_before = done_count;
    compare_addr(last_check.addr, sram_addr_t'(fault_addr), "last_check.addr");
    compare_data(last_check.expected, expected_word(pattern_state, last_check.addr),
                 "last_check.expected");
    compare_data(last_check.expected ^ last_check.read_data, sram_data_t'(1) << fault_bit,
                 "last_check bit difference");
    compare_kind(pattern_state, zeros, "pattern_state at halt");

    // halted tester must stay quiet
    for (int i = 0; i < halt_window; i++) begin
      @(negedge clk);
    end
    if (done_count != done_before) begin
      $display("** Error at %0t: test_done pulsed after the tester halted", $time);
      error_count++;
    end
    compare_bit(test_pass, 1'b0, "test_pass while halted");

    // recover through reset with the fault gone
    fault_enable = 1'b0;
    soft_reset   = 1'b1;
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
    end
    soft_reset    = 1'b0;
    pass_expected = 1'b1;
    compare_bit(test_pass, 1'b1, "test_pass after reset");
    wait_done(seq_limit);
    compare_bit(test_pass, 1'b1, "test_pass after recovery sequence");

    $display("errors: %0d wrong values, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: sim.f
src/sram_test_pkg.sv
src/sram_controller.sv
src/sram_pattern_generator.sv
src/sram_tester.sv
dv/tb_clock.sv
dv/sram_model.sv
dv/sram_tester_asserts.sv
dv/tb_sram_tester.sv

// File: src/sram_controller.sv
`timescale 1ns/1ns

module sram_controller #(
  parameter int ADDR_BITS = 20
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       req,
  input  sram_test_pkg::sram_req_t   request,
  output logic                       ready,
  output sram_test_pkg::sram_rsp_t   response,
  output sram_test_pkg::sram_pins_t  pins,
  inout  wire sram_test_pkg::sram_data_t io_data
);
  import sram_test_pkg::*;

  // only the low ADDR_BITS address lines ever toggle
  localparam sram_addr_t addr_mask = sram_addr_t'((64'd1 << ADDR_BITS) - 64'd1);

  ctrl_state_e state;
  // second cycle of write_drive
  logic        drive_phase;
  sram_addr_t  addr_q;
  sram_data_t  wdata_q;
  sram_data_t  rdata_q;
  logic        write_done_q;
  logic        read_valid_q;
  logic        drive_bus;
  logic        accept;

  assign accept = req && ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= idle;
      drive_phase <= 1'b0;
    end else begin
      case (state)
        idle: begin
          drive_phase <= 1'b0;
          if (accept) begin
            state <= request.write ? write_drive : read_drive;
          end
        end
        write_drive: begin
          // we_n held low for two cycles
          drive_phase <= ~drive_phase;
          if (drive_phase) begin
            state <= write_release;
          end
        end
        write_release: begin
          state <= idle;
        end
        read_drive: begin
          state <= read_sample;
        end
        read_sample: begin
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // capture the request in the accept cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q  <= request.addr & addr_mask;
      wdata_q <= request.data;
    end
  end

  // bus sampled at the end of read_sample
  always_ff @(posedge clk) begin
    if (state == read_sample) begin
      rdata_q <= io_data;
    end
  end

  // completion pulses; ready comes back the cycle after
  always_ff @(posedge clk) begin
    if (reset) begin
      ready        <= 1'b1;
      write_done_q <= 1'b0;
      read_valid_q <= 1'b0;
    end else begin
      write_done_q <= (state == write_drive) && drive_phase;
      read_valid_q <= (state == read_sample);
      if (accept) begin
        ready <= 1'b0;
      end else if (write_done_q || read_valid_q) begin
        ready <= 1'b1;
      end
    end
  end

  always_comb begin
    pins.addr = addr_q;
    pins.ce_n = (state == idle);
    pins.we_n = (state != write_drive);
    pins.oe_n = !((state == read_drive) || (state == read_sample));
  end

  // data still held while we_n rises in write_release
  assign drive_bus = (state == write_drive) || (state == write_release);
  assign io_data   = drive_bus ? wdata_q : 'z;

  assign response = '{write_done: write_done_q, read_valid: read_valid_q, read_data: rdata_q};

endmodule

// File: src/sram_pattern_generator.sv
`timescale 1ns/1ns

module sram_pattern_generator (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          restart,
  input  logic                          next_pattern,
  input  sram_test_pkg::sram_addr_t     addr,
  output sram_test_pkg::pattern_kind_e  kind,
  output logic                          is_last,
  output sram_test_pkg::sram_data_t     data
);
  import sram_test_pkg::*;

  // alternating bits, bit 0 clear
  localparam sram_data_t checker_word = {(data_bits / 2){2'b10}};

  assign is_last = (kind == pattern_last);

  always_ff @(posedge clk) begin
    if (reset) begin
      kind <= zeros;
    end else if (restart) begin
      kind <= zeros;
    end else if (next_pattern && !is_last) begin
      kind <= pattern_kind_e'(kind + 3'd1);
    end
  end

  // word for the current kind, addr only matters for addr_echo
  always_comb begin
    case (kind)
      zeros: begin
        data = '0;
      end
      ones: begin
        data = '1;
      end
      checker_a: begin
        data = checker_word;
      end
      checker_b: begin
        data = ~checker_word;
      end
      addr_echo: begin
        data = addr[data_bits-1:0];
      end
      default: begin
        data = '0;
      end
    endcase
  end

endmodule

// File: src/sram_test_pkg.sv
package sram_test_pkg;

  // word and address widths
  localparam int data_bits = 16;
  localparam int addr_max  = 20;

  typedef logic [data_bits-1:0] sram_data_t;
  typedef logic [addr_max-1:0]  sram_addr_t;

  // pattern written during one full write/read pass
  typedef enum logic [2:0] {
    zeros     = 3'd0,
    ones      = 3'd1,
    checker_a = 3'd2,
    checker_b = 3'd3,
    addr_echo = 3'd4
  } pattern_kind_e;

  localparam pattern_kind_e pattern_last = addr_echo;

  typedef enum logic [2:0] {
    start       = 3'd0,
    write_issue = 3'd1,
    write_wait  = 3'd2,
    read_issue  = 3'd3,
    read_wait   = 3'd4,
    check       = 3'd5,
    done        = 3'd6,
    halt        = 3'd7
  } tester_state_e;

  typedef enum logic [2:0] {
    idle          = 3'd0,
    write_drive   = 3'd1,
    write_release = 3'd2,
    read_drive    = 3'd3,
    read_sample   = 3'd4
  } ctrl_state_e;

  // tester to controller
  typedef struct packed {
    logic       write;
    sram_addr_t addr;
    sram_data_t data;
  } sram_req_t;

  // controller to tester, pulses plus read word
  typedef struct packed {
    logic       write_done;
    logic       read_valid;
    sram_data_t read_data;
  } sram_rsp_t;

  // active low SRAM controls, data bus kept apart as inout
  typedef struct packed {
    sram_addr_t addr;
    logic       ce_n;
    logic       oe_n;
    logic       we_n;
  } sram_pins_t;

  typedef struct packed {
    sram_addr_t addr;
    sram_data_t expected;
    sram_data_t read_data;
  } check_info_t;

endpackage

// File: src/sram_tester.sv
`timescale 1ns/1ns

module sram_tester #(
  parameter int ADDR_BITS = sram_test_pkg::addr_max
) (
  input  logic                          clk,
  input  logic                          reset,
  output sram_test_pkg::sram_pins_t     pins,
  inout  wire sram_test_pkg::sram_data_t io_data,
  output logic                          test_done,
  output logic                          test_pass,
  output sram_test_pkg::pattern_kind_e  pattern_state,
  output sram_test_pkg::check_info_t    last_check
);
  import sram_test_pkg::*;

  if (ADDR_BITS < 1 || ADDR_BITS > addr_max) begin : g_bad_width
    $error("ADDR_BITS must lie between 1 and addr_max");
  end

  tester_state_e          state;
  logic [ADDR_BITS-1:0]   addr_count;
  logic                   addr_top;
  sram_addr_t             cur_addr;

  logic                   req;
  logic                   ready;
  sram_req_t              request;
  sram_rsp_t              response;

  logic                   next_pattern;
  logic                   restart;
  pattern_kind_e          kind;
  logic                   is_last;
  sram_data_t             pattern_word;

  sram_data_t             read_q;
  sram_data_t             expected_q;
  logic                   mismatch;

  sram_controller #(
    .ADDR_BITS(ADDR_BITS)
  ) u_ctrl (
    .clk     (clk),
    .reset   (reset),
    .req     (req),
    .request (request),
    .ready   (ready),
    .response(response),
    .pins    (pins),
    .io_data (io_data)
  );

  sram_pattern_generator u_pattern (
    .clk         (clk),
    .reset       (reset),
    .restart     (restart),
    .next_pattern(next_pattern),
    .addr        (cur_addr),
    .kind        (kind),
    .is_last     (is_last),
    .data        (pattern_word)
  );

  // address counter, wraps back to zero after the top address
  assign addr_top = (addr_count == {ADDR_BITS{1'b1}});
  assign cur_addr = sram_addr_t'(addr_count);

  always_ff @(posedge clk) begin
    if (reset) begin
      addr_count <= '0;
    end else if ((state == write_wait && response.write_done) ||
                 (state == check && !mismatch)) begin
      addr_count <= addr_count + 1'b1;
    end
  end

  // sequencer
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= start;
    end else begin
      case (state)
        start: begin
          state <= write_issue;
        end
        write_issue: begin
          if (ready) begin
            state <= write_wait;
          end
        end
        write_wait: begin
          if (response.write_done) begin
            state <= addr_top ? read_issue : write_issue;
          end
        end
        read_issue: begin
          if (ready) begin
            state <= read_wait;
          end
        end
        read_wait: begin
          if (response.read_valid) begin
            state <= check;
          end
        end
        check: begin
          if (mismatch) begin
            state <= halt;
          end else if (addr_top) begin
            state <= is_last ? done : write_issue;
          end else begin
            state <= read_issue;
          end
        end
        done: begin
          state <= start;
        end
        halt: begin
          // stuck here until reset
          state <= halt;
        end
        default: begin
          state <= start;
        end
      endcase
    end
  end

  // one access per issue state, fields valid with req
  assign req     = ready && (state == write_issue || state == read_issue);
  assign request = '{write: (state == write_issue), addr: cur_addr, data: pattern_word};

  // read word and its expected value side by side for the check cycle
  always_ff @(posedge clk) begin
    if (state == read_wait && response.read_valid) begin
      read_q     <= response.read_data;
      expected_q <= pattern_word;
    end
  end

  assign mismatch = (read_q != expected_q);

  always_ff @(posedge clk) begin
    if (state == check) begin
      last_check <= '{addr: cur_addr, expected: expected_q, read_data: read_q};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      test_pass <= 1'b1;
    end else if (state == check && mismatch) begin
      test_pass <= 1'b0;
    end
  end

  // advance after the last good read of a pass, unless it was the final kind
  assign next_pattern  = (state == check) && !mismatch && addr_top && !is_last;
  assign restart       = (state == done);
  assign test_done     = (state == done);
  assign pattern_state = kind;

endmodule
